// File: src/video_pkg.sv
`default_nettype none

package video_pkg;

  // Line and map geometry
  localparam int line_width = 64;
  localparam int tile_size = 8;
  localparam int map_tiles = 16;
  localparam int world_bits = 7;
  localparam int line_x_bits = 6;

  // Data widths
  // Map entry layout: [5:0] tile index, [6] flip x, [7] flip y
  localparam int map_entry_bits = 8;
  localparam int color_index_bits = 8;
  localparam int rgb_bits = 18;
  localparam int pixel_addr_bits = 12;
  localparam int map_addr_bits = 8;

  // Control register fields
  localparam int ctrl_enable_bit = 0;
  localparam int ctrl_flip_bit = 1;
  localparam int ctrl_nop_bit = 2;
  localparam int ctrl_transp_bit = 3;

  // Cycles from map address issue to line buffer write
  localparam int pipe_latency = 3;
  // Cycles from scan_en sample to rgb
  localparam int scan_latency = 2;

  typedef enum logic [2:0] {
    reg_ctrl      = 3'd0,
    reg_scroll_x  = 3'd1,
    reg_scroll_y  = 3'd2,
    reg_nop_value = 3'd3,
    reg_color_key = 3'd4
  } cfg_reg_e;

  // Target of a memory load
  typedef enum logic [1:0] {
    sel_map,
    sel_pixel,
    sel_palette
  } mem_sel_e;

  typedef enum logic [1:0] {
    st_idle,
    st_draw,
    st_drain
  } render_state_e;

endpackage

`default_nettype wire

// File: src/render_config.sv
`default_nettype none

module render_config (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cfg_wr,
  input  video_pkg::cfg_reg_e               cfg_addr,
  input  logic [7:0]                        cfg_data,
  output logic                              layer_enable,
  output logic                              flip_enable,
  output logic                              nop_enable,
  output logic                              transp_enable,
  output logic [video_pkg::world_bits-1:0]  scroll_x,
  output logic [video_pkg::world_bits-1:0]  scroll_y,
  output logic [7:0]                        nop_value,
  output logic [7:0]                        color_key
);
  import video_pkg::*;

  logic [ctrl_transp_bit:0] ctrl;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl      <= '0;
      scroll_x  <= '0;
      scroll_y  <= '0;
      nop_value <= '0;
      color_key <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        reg_ctrl:      ctrl      <= cfg_data[ctrl_transp_bit:0];
        reg_scroll_x:  scroll_x  <= cfg_data[world_bits-1:0];
        reg_scroll_y:  scroll_y  <= cfg_data[world_bits-1:0];
        reg_nop_value: nop_value <= cfg_data;
        reg_color_key: color_key <= cfg_data;
        // Unlisted addresses are ignored
        default: ;
      endcase
    end
  end

  // Control bit decode
  assign layer_enable  = ctrl[ctrl_enable_bit];
  assign flip_enable   = ctrl[ctrl_flip_bit];
  assign nop_enable    = ctrl[ctrl_nop_bit];
  assign transp_enable = ctrl[ctrl_transp_bit];

endmodule

`default_nettype wire

// File: src/video_memories.sv
`default_nettype none

module video_memories (
  input  logic                                    clk,
  input  logic                                    mem_wr,
  input  video_pkg::mem_sel_e                     mem_sel,
  input  logic [video_pkg::pixel_addr_bits-1:0]   mem_addr,
  input  logic [video_pkg::rgb_bits-1:0]          mem_data,
  input  logic [video_pkg::map_addr_bits-1:0]     map_addr,
  input  logic [video_pkg::pixel_addr_bits-1:0]   pixel_addr,
  input  logic [video_pkg::color_index_bits-1:0]  pal_addr,
  output logic [video_pkg::map_entry_bits-1:0]    map_data,
  output logic [video_pkg::color_index_bits-1:0]  pixel_index,
  output logic [video_pkg::rgb_bits-1:0]          pal_data
);
  import video_pkg::*;

  // Tilemap, one entry per tile of the 16x16 map
  logic [map_entry_bits-1:0]   map_ram [map_tiles*map_tiles];
  // Tile pixels, 64 tiles of 8x8
  logic [color_index_bits-1:0] pixel_ram [2**pixel_addr_bits];
  logic [rgb_bits-1:0]         pal_ram [2**color_index_bits];

  // Load port, target picked by opcode
  always_ff @(posedge clk) begin
    if (mem_wr) begin
      case (mem_sel)
        sel_map: begin
          map_ram[mem_addr[map_addr_bits-1:0]] <= mem_data[map_entry_bits-1:0];
        end
        sel_pixel: begin
          pixel_ram[mem_addr] <= mem_data[color_index_bits-1:0];
        end
        sel_palette: begin
          pal_ram[mem_addr[color_index_bits-1:0]] <= mem_data;
        end
        default: ;
      endcase
    end
  end

  // Registered reads, one cycle latency each
  always_ff @(posedge clk) begin
    map_data    <= map_ram[map_addr];
    pixel_index <= pixel_ram[pixel_addr];
    pal_data    <= pal_ram[pal_addr];
  end

endmodule

`default_nettype wire

// File: src/render_sequencer.sv
`default_nettype none

module render_sequencer (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  line_start,
  input  logic [video_pkg::world_bits-1:0]      line_y,
  input  logic                                  layer_enable,
  input  logic [video_pkg::world_bits-1:0]      scroll_x,
  input  logic [video_pkg::world_bits-1:0]      scroll_y,
  output logic [video_pkg::map_addr_bits-1:0]   map_addr,
  output logic [2:0]                            tile_px,
  output logic [2:0]                            tile_py,
  output logic [video_pkg::line_x_bits-1:0]     issue_x,
  output logic                                  issue_valid,
  output logic                                  bank_swap,
  output logic                                  line_done
);
  import video_pkg::*;

  render_state_e           state;
  logic [line_x_bits-1:0]  x_cnt;
  logic [world_bits-1:0]   y_line;
  logic [1:0]              drain_cnt;
  logic [world_bits-1:0]   world_x;
  logic [world_bits-1:0]   world_y;

  // Only an idle sequencer accepts a line command
  assign bank_swap = line_start && (state == st_idle);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      x_cnt     <= '0;
      y_line    <= '0;
      drain_cnt <= '0;
      line_done <= 1'b0;
    end else begin
      line_done <= 1'b0;
      case (state)
        st_idle: begin
          if (line_start) begin
            if (layer_enable) begin
              state  <= st_draw;
              x_cnt  <= '0;
              y_line <= line_y;
            end else begin
              // Nothing to draw, finish right away
              line_done <= 1'b1;
            end
          end
        end
        st_draw: begin
          x_cnt <= x_cnt + 1'b1;
          if (x_cnt == line_x_bits'(line_width - 1)) begin
            state     <= st_drain;
            drain_cnt <= 2'd1;
          end
        end
        st_drain: begin
          // Let the last pixel reach the line buffer
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'(pipe_latency - 1)) begin
            state     <= st_idle;
            line_done <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // World coordinates wrap at 128
  assign world_x = {1'b0, x_cnt} + scroll_x;
  assign world_y = y_line + scroll_y;

  assign issue_valid = (state == st_draw);
  assign issue_x     = x_cnt;
  assign map_addr    = {world_y[world_bits-1:3], world_x[world_bits-1:3]};
  assign tile_px     = world_x[2:0];
  assign tile_py     = world_y[2:0];

endmodule

`default_nettype wire

// File: src/tile_entry_decode.sv
`default_nettype none

module tile_entry_decode (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   issue_valid,
  input  logic [2:0]                             tile_px,
  input  logic [2:0]                             tile_py,
  input  logic [video_pkg::line_x_bits-1:0]      issue_x,
  input  logic [video_pkg::map_entry_bits-1:0]   map_data,
  input  logic                                   flip_enable,
  input  logic                                   nop_enable,
  input  logic [7:0]                             nop_value,
  output logic [video_pkg::pixel_addr_bits-1:0]  pixel_addr,
  output logic                                   pixel_valid,
  output logic [video_pkg::line_x_bits-1:0]      pixel_x,
  output logic                                   pixel_skip
);
  import video_pkg::*;

  logic [2:0] px_q;
  logic [2:0] py_q;
  logic       flip_x;
  logic       flip_y;
  logic [2:0] px_f;
  logic [2:0] py_f;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= issue_valid;
    end
  end

  // Align coordinates with the map RAM output
  always_ff @(posedge clk) begin
    px_q    <= tile_px;
    py_q    <= tile_py;
    pixel_x <= issue_x;
  end

  // Flip bits only count when flipping is on
  assign flip_x = flip_enable && map_data[6];
  assign flip_y = flip_enable && map_data[7];
  assign px_f   = flip_x ? 3'(tile_size - 1) - px_q : px_q;
  assign py_f   = flip_y ? 3'(tile_size - 1) - py_q : py_q;

  // Tile index is the low six bits either way
  assign pixel_addr = {map_data[5:0], py_f, px_f};
  assign pixel_skip = nop_enable && (map_data == nop_value);

endmodule

`default_nettype wire

// File: src/line_buffer.sv
`default_nettype none

module line_buffer (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    pixel_valid,
  input  logic                                    pixel_skip,
  input  logic [video_pkg::line_x_bits-1:0]       pixel_x,
  input  logic [video_pkg::color_index_bits-1:0]  pixel_index,
  input  logic                                    transp_enable,
  input  logic [7:0]                              color_key,
  input  logic [video_pkg::rgb_bits-1:0]          pal_data,
  input  logic                                    bank_swap,
  input  logic                                    scan_en,
  input  logic [video_pkg::line_x_bits-1:0]       scan_x,
  output logic [video_pkg::color_index_bits-1:0]  pal_addr,
  output logic [video_pkg::rgb_bits-1:0]          rgb
);
  import video_pkg::*;

  // Two banks of one line each, bank select is the address MSB
  logic [rgb_bits-1:0]         buf_mem [2*line_width];
  logic                        bank_sel;
  logic                        valid_d1;
  logic                        valid_d2;
  logic                        skip_d1;
  logic                        skip_d2;
  logic [line_x_bits-1:0]      x_d1;
  logic [line_x_bits-1:0]      x_d2;
  logic [color_index_bits-1:0] index_d;
  logic                        key_hit;
  logic                        buf_wr;
  logic                        scan_en_q;
  logic [rgb_bits-1:0]         scan_data;

  // Pixel value goes straight to the palette
  assign pal_addr = pixel_index;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      bank_sel  <= 1'b0;
      valid_d1  <= 1'b0;
      valid_d2  <= 1'b0;
      scan_en_q <= 1'b0;
      rgb       <= '0;
    end else begin
      if (bank_swap) begin
        bank_sel <= ~bank_sel;
      end
      valid_d1  <= pixel_valid;
      valid_d2  <= valid_d1;
      scan_en_q <= scan_en;
      // Blank output when not scanning
      rgb <= scan_en_q ? scan_data : '0;
    end
  end

  // Side data delayed to meet pal_data
  always_ff @(posedge clk) begin
    skip_d1 <= pixel_skip;
    skip_d2 <= skip_d1;
    x_d1    <= pixel_x;
    x_d2    <= x_d1;
    index_d <= pixel_index;
  end

  assign key_hit = transp_enable && (index_d == color_key);
  assign buf_wr  = valid_d2 && !skip_d2 && !key_hit;

  // Render into the back bank, scan out the front one
  always_ff @(posedge clk) begin
    if (buf_wr) begin
      buf_mem[{bank_sel, x_d2}] <= pal_data;
    end
    scan_data <= buf_mem[{~bank_sel, scan_x}];
  end

endmodule

`default_nettype wire

// File: src/tile_renderer.sv
`default_nettype none

module tile_renderer (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   cfg_wr,
  input  video_pkg::cfg_reg_e                    cfg_addr,
  input  logic [7:0]                             cfg_data,
  input  logic                                   mem_wr,
  input  video_pkg::mem_sel_e                    mem_sel,
  input  logic [video_pkg::pixel_addr_bits-1:0]  mem_addr,
  input  logic [video_pkg::rgb_bits-1:0]         mem_data,
  input  logic                                   line_start,
  input  logic [video_pkg::world_bits-1:0]       line_y,
  input  logic                                   scan_en,
  input  logic [video_pkg::line_x_bits-1:0]      scan_x,
  output logic                                   line_done,
  output logic [video_pkg::rgb_bits-1:0]         rgb
);
  import video_pkg::*;

  // Configuration
  logic                        layer_enable;
  logic                        flip_enable;
  logic                        nop_enable;
  logic                        transp_enable;
  logic [world_bits-1:0]       scroll_x;
  logic [world_bits-1:0]       scroll_y;
  logic [7:0]                  nop_value;
  logic [7:0]                  color_key;

  // Render pipeline
  logic [map_addr_bits-1:0]    map_addr;
  logic [map_entry_bits-1:0]   map_data;
  logic [2:0]                  tile_px;
  logic [2:0]                  tile_py;
  logic [line_x_bits-1:0]      issue_x;
  logic                        issue_valid;
  logic                        bank_swap;
  logic [pixel_addr_bits-1:0]  pixel_addr;
  logic                        pixel_valid;
  logic [line_x_bits-1:0]      pixel_x;
  logic                        pixel_skip;
  logic [color_index_bits-1:0] pixel_index;
  logic [color_index_bits-1:0] pal_addr;
  logic [rgb_bits-1:0]         pal_data;

  render_config u_config (
    .clk(clk), .reset(reset),
    .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
    .layer_enable(layer_enable), .flip_enable(flip_enable),
    .nop_enable(nop_enable), .transp_enable(transp_enable),
    .scroll_x(scroll_x), .scroll_y(scroll_y),
    .nop_value(nop_value), .color_key(color_key)
  );

  video_memories u_memories (
    .clk(clk),
    .mem_wr(mem_wr), .mem_sel(mem_sel), .mem_addr(mem_addr), .mem_data(mem_data),
    .map_addr(map_addr), .pixel_addr(pixel_addr), .pal_addr(pal_addr),
    .map_data(map_data), .pixel_index(pixel_index), .pal_data(pal_data)
  );

  render_sequencer u_sequencer (
    .clk(clk), .reset(reset),
    .line_start(line_start), .line_y(line_y), .layer_enable(layer_enable),
    .scroll_x(scroll_x), .scroll_y(scroll_y),
    .map_addr(map_addr), .tile_px(tile_px), .tile_py(tile_py),
    .issue_x(issue_x), .issue_valid(issue_valid),
    .bank_swap(bank_swap), .line_done(line_done)
  );

  tile_entry_decode u_decode (
    .clk(clk), .reset(reset),
    .issue_valid(issue_valid), .tile_px(tile_px), .tile_py(tile_py),
    .issue_x(issue_x), .map_data(map_data),
    .flip_enable(flip_enable), .nop_enable(nop_enable), .nop_value(nop_value),
    .pixel_addr(pixel_addr), .pixel_valid(pixel_valid),
    .pixel_x(pixel_x), .pixel_skip(pixel_skip)
  );

  line_buffer u_line_buffer (
    .clk(clk), .reset(reset),
    .pixel_valid(pixel_valid), .pixel_skip(pixel_skip), .pixel_x(pixel_x),
    .pixel_index(pixel_index), .transp_enable(transp_enable),
    .color_key(color_key), .pal_data(pal_data), .bank_swap(bank_swap),
    .scan_en(scan_en), .scan_x(scan_x),
    .pal_addr(pal_addr), .rgb(rgb)
  );

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
`default_nettype none

module clock_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Release reset just after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/tb_tile_renderer.sv
`default_nettype none

module tb_tile_renderer;
  import video_pkg::*;

  localparam int clk_period     = 4;
  localparam     input_file     = "tb/render_input.txt";
  localparam int record_cycles  = 80;
  localparam int timeout_margin = 200;

  logic                        clk;
  logic                        reset;
  logic                        cfg_wr;
  cfg_reg_e                    cfg_addr;
  logic [7:0]                  cfg_data;
  logic                        mem_wr;
  mem_sel_e                    mem_sel;
  logic [pixel_addr_bits-1:0]  mem_addr;
  logic [rgb_bits-1:0]         mem_data;
  logic                        line_start;
  logic [world_bits-1:0]       line_y;
  logic                        scan_en;
  logic [line_x_bits-1:0]      scan_x;
  logic                        line_done;
  logic [rgb_bits-1:0]         rgb;

  int    fd;
  int    budget = timeout_margin;
  int    cycle_count = 0;
  int    error_count = 0;
  int    test_errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  bit    test_open = 1'b0;
  bit    scan_group_en = 1'b0;
  string test_name;

  clock_gen #(.period(clk_period)) u_clock (.clk(clk), .reset(reset));

  tile_renderer uut (
    .clk(clk), .reset(reset),
    .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
    .mem_wr(mem_wr), .mem_sel(mem_sel), .mem_addr(mem_addr), .mem_data(mem_data),
    .line_start(line_start), .line_y(line_y),
    .scan_en(scan_en), .scan_x(scan_x),
    .line_done(line_done), .rgb(rgb)
  );

  // Memory images used by the F records
  function automatic logic [rgb_bits-1:0] fill_value(input int sel, input logic [11:0] a);
    logic [rgb_bits-1:0] value;
    if (sel == 0) begin
      // Map entry with the address nibbles swapped
      value = {10'd0, a[3:0], a[7:4]};
    end else if (sel == 1) begin
      value = {10'd0, a[7:0] ^ {4'd0, a[11:8]}};
    end else begin
      value = {a[1:0], a[7:0], ~a[7:0]};
    end
    return value;
  endfunction

  task automatic count_error();
    error_count++;
    test_errors++;
  endtask

  task automatic close_test();
    if (test_open) begin
      if (test_errors == 0) begin
        $display("PASS %s", test_name);
        tests_passed++;
      end else begin
        $display("FAIL %s with %0d errors", test_name, test_errors);
        tests_failed++;
      end
    end
    test_open = 1'b0;
  endtask

  task automatic write_config(input int addr, input int data);
    cfg_wr   = 1'b1;
    cfg_addr = cfg_reg_e'(addr[2:0]);
    cfg_data = data[7:0];
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic write_memory(input int sel, input int addr, input int data);
    mem_wr   = 1'b1;
    mem_sel  = mem_sel_e'(sel[1:0]);
    mem_addr = addr[pixel_addr_bits-1:0];
    mem_data = data[rgb_bits-1:0];
    @(posedge clk);
    #1;
    mem_wr = 1'b0;
  endtask

  task automatic fill_memory(input int sel);
    int size;
    int a;
    size = (sel == 1) ? 4096 : 256;
    budget += size;
    for (a = 0; a < size; a++) begin
      mem_wr   = 1'b1;
      mem_sel  = mem_sel_e'(sel[1:0]);
      mem_addr = a[pixel_addr_bits-1:0];
      mem_data = fill_value(sel, a[11:0]);
      @(posedge clk);
      #1;
    end
    mem_wr = 1'b0;
  endtask

  // Counts edges from the line_start sample to the first line_done seen
  task automatic line_command(input int y, input int expected_cycles);
    int cycles;
    line_y     = y[world_bits-1:0];
    line_start = 1'b1;
    @(posedge clk);
    #1;
    line_start = 1'b0;
    cycles     = 1;
    while (line_done !== 1'b1) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles != expected_cycles) begin
      $display("[ERROR] t=%0t line_y=%0d line_done after %0d cycles, expected %0d",
               $time, y, cycles, expected_cycles);
      count_error();
    end
  endtask

  // Second command brings the drawn bank to the front and redraws into the other
  task automatic render_line(input int y, input int expected_cycles);
    line_command(y, expected_cycles);
    line_command(y, expected_cycles);
  endtask

  task automatic check_pixel(input int x, input logic [rgb_bits-1:0] expected);
    scan_en = scan_group_en;
    scan_x  = x[line_x_bits-1:0];
    repeat (scan_latency) @(posedge clk);
    #1;
    if (rgb !== expected) begin
      $display("[ERROR] t=%0t x=%0d expected %05h got %05h", $time, x, expected, rgb);
      count_error();
    end
  endtask

  task automatic read_records();
    string kind;
    int    code;
    int    ch;
    int    f1;
    int    f2;
    int    f3;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", kind);
      if (code == 1) begin
        if (kind == "#") begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else begin
          budget += record_cycles;
          if (kind == "T") begin
            close_test();
            code        = $fscanf(fd, "%s", test_name);
            test_open   = 1'b1;
            test_errors = 0;
          end else if (kind == "F") begin
            code = $fscanf(fd, "%h", f1);
            fill_memory(f1);
          end else if (kind == "M") begin
            code = $fscanf(fd, "%h %h %h", f1, f2, f3);
            write_memory(f1, f2, f3);
          end else if (kind == "C") begin
            code = $fscanf(fd, "%h %h", f1, f2);
            write_config(f1, f2);
          end else if (kind == "L") begin
            code = $fscanf(fd, "%h %h", f1, f2);
            render_line(f1, f2);
          end else if (kind == "S") begin
            code          = $fscanf(fd, "%h", f1);
            scan_group_en = f1[0];
            scan_en       = f1[0];
          end else if (kind == "E") begin
            code = $fscanf(fd, "%h %h", f1, f2);
            check_pixel(f1, f2[rgb_bits-1:0]);
          end else begin
            $display("Unknown record type %s in the input file", kind);
            count_error();
          end
        end
      end
    end
  endtask

  // Budget grows with every record read and stops growing when the run stalls
  initial begin
    while (cycle_count <= budget) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles: line_done never came", cycle_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    cfg_wr     = 1'b0;
    cfg_addr   = reg_ctrl;
    cfg_data   = '0;
    mem_wr     = 1'b0;
    mem_sel    = sel_map;
    mem_addr   = '0;
    mem_data   = '0;
    line_start = 1'b0;
    line_y     = '0;
    scan_en    = 1'b0;
    scan_x     = '0;
    // First edge with reset still held
    @(posedge clk);
    #1;
    if (rgb !== '0 || line_done !== 1'b0) begin
      $display("[ERROR] t=%0t outputs not idle in reset, rgb=%05h line_done=%b",
               $time, rgb, line_done);
      error_count++;
    end
    @(negedge reset);
    @(posedge clk);
    #1;
    fd = $fopen(input_file, "r");
    if (fd == 0) begin
      $display("Could not open the input file %s", input_file);
      error_count++;
    end else begin
      read_records();
      $fclose(fd);
    end
    close_test();
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/render_input.txt
# Records (hex fields): F sel | M sel addr data | C reg data | L line_y cycles | S scan_en
# E x rgb | T name; sel 0 map, 1 pixel, 2 palette; cycles from line_start to line_done
F 0
F 1
F 2
T plain_render
C 0 01
L 0b 43
S 1
E 00 058a7
E 0d 159a6
E 26 25ea1
E 3f 353ac
T scroll_wrap
C 1 7c
C 2 7a
L 09 43
S 1
E 00 010ef
E 04 018e7
E 3f 317e8
T flips
C 1 20
C 2 00
C 0 03
L 0b 43
S 1
E 00 35fa0
E 06 159a6
E 28 0649b
E 3f 36b94
T nop_and_key
C 3 91
C 4 61
C 0 0f
L 0c 43
S 1
E 00 36798
E 06 159a6
E 28 0649b
E 3f 353ac
T disabled_layer
C 0 00
L 0b 01
S 1
E 00 36798
E 06 159a6
S 0
E 00 00000

// File: list.f
src/video_pkg.sv
src/render_config.sv
src/video_memories.sv
src/render_sequencer.sv
src/tile_entry_decode.sv
src/line_buffer.sv
src/tile_renderer.sv
tb/clock_gen.sv
tb/tb_tile_renderer.sv

// File: Bender.yml
package:
  name: tile_renderer

sources:
  - files:
      - src/video_pkg.sv
      - src/render_config.sv
      - src/video_memories.sv
      - src/render_sequencer.sv
      - src/tile_entry_decode.sv
      - src/line_buffer.sv
      - src/tile_renderer.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/tb_tile_renderer.sv
